// ==== source/retry_params.svh ====
`ifndef RETRY_PARAMS_SVH
`define RETRY_PARAMS_SVH

// beat data width in bits
`define RTX_DATA_WIDTH 32

// sideband bits per beat
`define RTX_USER_WIDTH 1

// number of replay slots
`define RTX_SLOTS 4

// beats per slot buffer
`define RTX_DEPTH 16

`endif

// ==== source/pcie_datalink_pkg.sv ====
`include "retry_params.svh"

package pcie_datalink_pkg;

  typedef logic [`RTX_DATA_WIDTH-1:0] tlp_data_t;

  // one enable per byte lane
  typedef logic [`RTX_DATA_WIDTH/8-1:0] tlp_keep_t;

  typedef logic [`RTX_USER_WIDTH-1:0] tlp_user_t;

  // storage word of a replay buffer
  typedef struct packed {
    tlp_data_t data;
    tlp_keep_t keep;
    tlp_user_t user;
    logic      last;  // final beat of the TLP
  } tlp_beat_t;

endpackage

// ==== source/retry_ctrl_pkg.sv ====
`include "retry_params.svh"

package retry_ctrl_pkg;

  typedef logic [$clog2(`RTX_SLOTS)-1:0] slot_idx_t;
  typedef logic [`RTX_SLOTS-1:0] slot_mask_t;

  typedef enum logic [1:0] {
    replay_idle,
    replay_stream,
    replay_done  // one guard cycle after completion
  } replay_state_e;

  // lowest set bit wins
  function automatic slot_idx_t lowest_slot(input slot_mask_t mask);
    slot_idx_t idx;
    idx = '0;
    for (int i = `RTX_SLOTS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = slot_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

// ==== source/axis_retry_fifo.sv ====
`timescale 1ns/100ps

`include "retry_params.svh"

module axis_retry_fifo (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         wr_en_i,
  input  pcie_datalink_pkg::tlp_beat_t wr_beat_i,
  input  logic                         clear_i,
  input  logic                         rd_ready_i,
  input  logic                         rewind_i,
  output pcie_datalink_pkg::tlp_beat_t rd_beat_o,
  output logic                         rd_valid_o,
  output logic                         stored_o
);

  import pcie_datalink_pkg::*;

  localparam int PTR_W = $clog2(`RTX_DEPTH);

  tlp_beat_t        mem [`RTX_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W-1:0] last_ptr_r;  // entry holding the last beat
  logic             stored_r;
  logic             rd_done_r;
  logic             wr_accept;
  logic             pop;

  // a stored TLP is never overwritten, only cleared
  assign wr_accept = wr_en_i && !stored_r;
  assign pop       = rd_ready_i && rd_valid_o;

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      mem[wr_ptr_r] <= wr_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept && wr_beat_i.last) begin
      last_ptr_r <= wr_ptr_r;
    end
  end

  // write side
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      wr_ptr_r <= '0;
      stored_r <= 1'b0;
    end else if (wr_accept) begin
      wr_ptr_r <= wr_ptr_r + 1'b1;
      if (wr_beat_i.last) begin
        stored_r <= 1'b1;
      end
    end
  end

  // read side, rewind restarts the replay from entry 0
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i || rewind_i) begin
      rd_ptr_r  <= '0;
      rd_done_r <= 1'b0;
    end else if (pop) begin
      if (rd_ptr_r == last_ptr_r) begin
        rd_done_r <= 1'b1;  // hold pointer on the last entry
      end else begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  assign rd_beat_o  = mem[rd_ptr_r];
  assign rd_valid_o = stored_r && !rd_done_r;
  assign stored_o   = stored_r;

endmodule

// ==== source/retry_slot_alloc.sv ====
`timescale 1ns/100ps

module retry_slot_alloc (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       s_valid_i,
  input  logic                       s_last_i,
  output logic                       s_ready_o,
  input  retry_ctrl_pkg::slot_mask_t stored_i,
  input  retry_ctrl_pkg::slot_mask_t purge_i,
  input  retry_ctrl_pkg::slot_mask_t busy_i,
  output retry_ctrl_pkg::slot_mask_t wr_en_o,
  output retry_ctrl_pkg::slot_mask_t clear_o,
  output retry_ctrl_pkg::slot_mask_t occupied_o
);

  import retry_ctrl_pkg::*;

  logic       writing_r;  // inside a TLP
  logic       ready_r;
  slot_idx_t  wr_slot_r;
  slot_idx_t  cur_slot;
  slot_mask_t cur_mask;
  slot_mask_t occ_next;
  logic       xfer;
  logic       writing_next;

  // slot is locked from first beat to last
  assign cur_slot = writing_r ? wr_slot_r : lowest_slot(~stored_i);
  assign cur_mask = slot_mask_t'(1) << cur_slot;
  assign xfer     = s_valid_i && ready_r;

  assign wr_en_o = xfer ? cur_mask : '0;

  // purge never hits the slot under replay
  assign clear_o    = purge_i & stored_i & ~busy_i;
  assign occupied_o = stored_i;

  // occupancy as the buffers will see it after this edge
  assign occ_next     = (stored_i & ~clear_o) | ((xfer && s_last_i) ? cur_mask : '0);
  assign writing_next = xfer ? !s_last_i : writing_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      writing_r <= 1'b0;
      ready_r   <= 1'b0;
      wr_slot_r <= '0;
    end else begin
      writing_r <= writing_next;
      ready_r   <= writing_next || (occ_next != '1);
      if (xfer && !writing_r) begin
        wr_slot_r <= cur_slot;  // first beat picks the slot
      end
    end
  end

  assign s_ready_o = ready_r;

endmodule

// ==== source/retry_transmit.sv ====
`timescale 1ns/100ps

`include "retry_params.svh"

module retry_transmit (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  retry_ctrl_pkg::slot_mask_t   retry_valid_i,
  output retry_ctrl_pkg::slot_mask_t   retry_ack_o,
  output retry_ctrl_pkg::slot_mask_t   retry_complete_o,
  output retry_ctrl_pkg::slot_mask_t   rd_ready_o,
  output retry_ctrl_pkg::slot_mask_t   rewind_o,
  output retry_ctrl_pkg::slot_mask_t   busy_o,
  input  pcie_datalink_pkg::tlp_beat_t rd_beat_i [`RTX_SLOTS],
  input  retry_ctrl_pkg::slot_mask_t   rd_valid_i,
  output pcie_datalink_pkg::tlp_data_t m_axis_tdata_o,
  output pcie_datalink_pkg::tlp_keep_t m_axis_tkeep_o,
  output pcie_datalink_pkg::tlp_user_t m_axis_tuser_o,
  output logic                         m_axis_tlast_o,
  output logic                         m_axis_tvalid_o,
  input  logic                         m_axis_tready_i
);

  import pcie_datalink_pkg::*;
  import retry_ctrl_pkg::*;

  replay_state_e state_r;
  replay_state_e state_nxt;
  slot_idx_t     grant_r;
  slot_mask_t    grant_mask;
  slot_mask_t    ack_r;
  tlp_beat_t     out_beat_r;
  logic          out_valid_r;
  logic          load;
  logic          last_xfer;

  assign grant_mask = slot_mask_t'(1) << grant_r;

  // output register, refilled whenever empty or being taken
  assign load = (state_r == replay_stream) && !(out_valid_r && out_beat_r.last) &&
                (!out_valid_r || m_axis_tready_i);

  assign last_xfer = out_valid_r && out_beat_r.last && m_axis_tready_i;

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      replay_idle: begin
        if (retry_valid_i != '0) begin
          state_nxt = replay_stream;
        end
      end
      replay_stream: begin
        if (last_xfer) begin
          state_nxt = replay_done;
        end
      end
      default: begin
        // requester drops its bit during this cycle
        state_nxt = replay_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= replay_idle;
      grant_r <= '0;
      ack_r   <= '0;
    end else begin
      state_r <= state_nxt;
      if (state_r == replay_idle && retry_valid_i != '0) begin
        grant_r <= lowest_slot(retry_valid_i);
        ack_r   <= slot_mask_t'(1) << lowest_slot(retry_valid_i);
      end else if (last_xfer) begin
        ack_r <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_r <= 1'b0;
    end else if (last_xfer) begin
      out_valid_r <= 1'b0;
    end else if (load) begin
      out_valid_r <= rd_valid_i[grant_r];
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_beat_r <= rd_beat_i[grant_r];
    end
  end

  // only the granted buffer sees ready
  assign rd_ready_o       = load ? grant_mask : '0;
  assign rewind_o         = last_xfer ? grant_mask : '0;
  assign retry_complete_o = last_xfer ? grant_mask : '0;
  assign retry_ack_o      = ack_r;
  assign busy_o           = (state_r != replay_idle) ? grant_mask : '0;

  assign m_axis_tdata_o  = out_beat_r.data;
  assign m_axis_tkeep_o  = out_beat_r.keep;
  assign m_axis_tuser_o  = out_beat_r.user;
  assign m_axis_tlast_o  = out_beat_r.last;
  assign m_axis_tvalid_o = out_valid_r;

endmodule

// ==== source/retry_subsystem.sv ====
`timescale 1ns/100ps

`include "retry_params.svh"

module retry_subsystem (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  pcie_datalink_pkg::tlp_data_t s_axis_tdata_i,
  input  pcie_datalink_pkg::tlp_keep_t s_axis_tkeep_i,
  input  pcie_datalink_pkg::tlp_user_t s_axis_tuser_i,
  input  logic                         s_axis_tlast_i,
  input  logic                         s_axis_tvalid_i,
  output logic                         s_axis_tready_o,
  output pcie_datalink_pkg::tlp_data_t m_axis_tdata_o,
  output pcie_datalink_pkg::tlp_keep_t m_axis_tkeep_o,
  output pcie_datalink_pkg::tlp_user_t m_axis_tuser_o,
  output logic                         m_axis_tlast_o,
  output logic                         m_axis_tvalid_o,
  input  logic                         m_axis_tready_i,
  input  retry_ctrl_pkg::slot_mask_t   retry_valid_i,
  input  retry_ctrl_pkg::slot_mask_t   purge_i,
  output retry_ctrl_pkg::slot_mask_t   retry_ack_o,
  output retry_ctrl_pkg::slot_mask_t   retry_complete_o,
  output retry_ctrl_pkg::slot_mask_t   occupied_o
);

  import pcie_datalink_pkg::*;
  import retry_ctrl_pkg::*;

  tlp_beat_t  wr_beat;
  tlp_beat_t  rd_beat [`RTX_SLOTS];
  slot_mask_t wr_en;
  slot_mask_t clear;
  slot_mask_t stored;
  slot_mask_t busy;
  slot_mask_t rd_ready;
  slot_mask_t rd_valid;
  slot_mask_t rewind;
  slot_mask_t occupied;
  slot_mask_t retry_req;

  assign wr_beat.data = s_axis_tdata_i;
  assign wr_beat.keep = s_axis_tkeep_i;
  assign wr_beat.user = s_axis_tuser_i;
  assign wr_beat.last = s_axis_tlast_i;

  assign retry_req  = retry_valid_i & occupied;  // empty slots cannot be replayed
  assign occupied_o = occupied;

  retry_slot_alloc i_slot_alloc (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .s_valid_i  (s_axis_tvalid_i),
    .s_last_i   (s_axis_tlast_i),
    .s_ready_o  (s_axis_tready_o),
    .stored_i   (stored),
    .purge_i    (purge_i),
    .busy_i     (busy),
    .wr_en_o    (wr_en),
    .clear_o    (clear),
    .occupied_o (occupied)
  );

  for (genvar i = 0; i < `RTX_SLOTS; i++) begin : gen_slot
    axis_retry_fifo i_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_en_i    (wr_en[i]),
      .wr_beat_i  (wr_beat),
      .clear_i    (clear[i]),
      .rd_ready_i (rd_ready[i]),
      .rewind_i   (rewind[i]),
      .rd_beat_o  (rd_beat[i]),
      .rd_valid_o (rd_valid[i]),
      .stored_o   (stored[i])
    );
  end

  retry_transmit i_transmit (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .retry_valid_i    (retry_req),
    .retry_ack_o      (retry_ack_o),
    .retry_complete_o (retry_complete_o),
    .rd_ready_o       (rd_ready),
    .rewind_o         (rewind),
    .busy_o           (busy),
    .rd_beat_i        (rd_beat),
    .rd_valid_i       (rd_valid),
    .m_axis_tdata_o   (m_axis_tdata_o),
    .m_axis_tkeep_o   (m_axis_tkeep_o),
    .m_axis_tuser_o   (m_axis_tuser_o),
    .m_axis_tlast_o   (m_axis_tlast_o),
    .m_axis_tvalid_o  (m_axis_tvalid_o),
    .m_axis_tready_i  (m_axis_tready_i)
  );

endmodule

// ==== dv/retry_subsystem_properties.sv ====
`timescale 1ns/100ps

module retry_subsystem_properties (
  input logic                         clk_i,
  input logic                         rst_i,
  input retry_ctrl_pkg::slot_mask_t   retry_valid_i,
  input retry_ctrl_pkg::slot_mask_t   retry_ack_o,
  input retry_ctrl_pkg::slot_mask_t   retry_complete_o,
  input pcie_datalink_pkg::tlp_data_t m_axis_tdata_o,
  input logic                         m_axis_tlast_o,
  input logic                         m_axis_tvalid_o,
  input logic                         m_axis_tready_i
);

  // a stalled beat stays on the bus
  valid_held_a : assert property (@(posedge clk_i) disable iff (rst_i)
    m_axis_tvalid_o && !m_axis_tready_i |=> m_axis_tvalid_o)
    else $error("m_axis_tvalid_o dropped before the beat transferred");

  data_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    m_axis_tvalid_o && !m_axis_tready_i |=> $stable(m_axis_tdata_o) && $stable(m_axis_tlast_o))
    else $error("output beat changed while stalled");

  // a new grant goes to the lowest requested slot
  grant_lowest_a : assert property (@(posedge clk_i) disable iff (rst_i)
    retry_ack_o != '0 && $past(retry_ack_o) == '0 |->
      retry_ack_o == ($past(retry_valid_i) & (~$past(retry_valid_i) + 1'b1)))
    else $error("retry_ack_o is not the lowest requested slot");

  // completion only for the granted slot
  complete_a : assert property (@(posedge clk_i) disable iff (rst_i)
    retry_complete_o != '0 |-> retry_complete_o == retry_ack_o)
    else $error("retry_complete_o does not match the granted slot");

endmodule

bind retry_transmit retry_subsystem_properties i_props (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .retry_valid_i    (retry_valid_i),
  .retry_ack_o      (retry_ack_o),
  .retry_complete_o (retry_complete_o),
  .m_axis_tdata_o   (m_axis_tdata_o),
  .m_axis_tlast_o   (m_axis_tlast_o),
  .m_axis_tvalid_o  (m_axis_tvalid_o),
  .m_axis_tready_i  (m_axis_tready_i)
);

// ==== dv/retry_checker.sv ====
`timescale 1ns/100ps

module retry_checker (
  input logic                         clk_i,
  input logic                         rst_i,
  input pcie_datalink_pkg::tlp_data_t m_tdata_i,
  input pcie_datalink_pkg::tlp_keep_t m_tkeep_i,
  input pcie_datalink_pkg::tlp_user_t m_tuser_i,
  input logic                         m_tlast_i,
  input logic                         m_tvalid_i,
  input logic                         m_tready_i,
  input retry_ctrl_pkg::slot_mask_t   ack_i,
  input retry_ctrl_pkg::slot_mask_t   complete_i
);

  import pcie_datalink_pkg::*;
  import retry_ctrl_pkg::*;

  string      name_q[$];
  int         slot_q[$];
  int         len_q[$];
  tlp_data_t  word_q[$];
  tlp_data_t  exp_word;
  slot_mask_t exp_mask;
  logic       exp_last;
  int         beat_idx  = 0;
  int         test_errs = 0;
  int         pass_cnt  = 0;
  int         fail_cnt  = 0;

  task automatic add_test(input string name, input int slot, input int len);
    name_q.push_back(name);
    slot_q.push_back(slot);
    len_q.push_back(len);
  endtask

  task automatic add_word(input tlp_data_t w);
    word_q.push_back(w);
  endtask

  function automatic int pending();
    return name_q.size();
  endfunction

  task automatic report_failure(input string name, input string what);
    $display("test %s: failed, %s", name, what);
    fail_cnt++;
  endtask

  task automatic check_mask(input string name, input slot_mask_t exp, input slot_mask_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      $display("test %s: failed", name);
      fail_cnt++;
    end else begin
      $display("test %s: passed", name);
      pass_cnt++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error %s: expected %0d cycles, actual %0d cycles", name, exp, act);
      $display("test %s: failed", name);
      fail_cnt++;
    end else begin
      $display("test %s: passed", name);
      pass_cnt++;
    end
  endtask

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error %s %s: expected %h, actual %h", name_q[0], what, exp, act);
    test_errs++;
  endtask

  always @(posedge clk_i) begin
    if (!rst_i && m_tvalid_i && m_tready_i) begin
      if (name_q.size() == 0) begin
        report_failure("stream", "output beat seen with no replay expected");
      end else if (beat_idx >= len_q[0]) begin
        value_error("beat count", len_q[0], beat_idx + 1);
      end else begin
        exp_word = word_q.pop_front();
        exp_last = (beat_idx == len_q[0] - 1);
        exp_mask = slot_mask_t'(1) << slot_q[0];
        if (m_tdata_i !== exp_word) value_error("data", exp_word, m_tdata_i);
        if (m_tkeep_i !== '1) value_error("keep", 32'hf, m_tkeep_i);
        // stimulus alternates the user bit per beat
        if (m_tuser_i !== tlp_user_t'(beat_idx % 2)) value_error("user", beat_idx % 2, m_tuser_i);
        if (m_tlast_i !== exp_last) value_error("last", exp_last, m_tlast_i);
        if (ack_i !== exp_mask) value_error("ack", exp_mask, ack_i);
        beat_idx++;
      end
    end
    if (!rst_i && complete_i != '0) begin
      if (name_q.size() == 0) begin
        report_failure("complete", "completion pulse with no replay expected");
      end else begin
        exp_mask = slot_mask_t'(1) << slot_q[0];
        if (complete_i !== exp_mask) value_error("complete", exp_mask, complete_i);
        if (beat_idx != len_q[0]) value_error("beat count", len_q[0], beat_idx);
        if (!(m_tvalid_i && m_tready_i && m_tlast_i)) begin
          value_error("complete on last transfer", 1, 0);
        end
        if (test_errs == 0) begin
          $display("test %s: passed", name_q[0]);
          pass_cnt++;
        end else begin
          $display("test %s: failed", name_q[0]);
          fail_cnt++;
        end
        void'(name_q.pop_front());
        void'(slot_q.pop_front());
        void'(len_q.pop_front());
        beat_idx  = 0;
        test_errs = 0;
      end
    end
  end

endmodule

// ==== dv/retry_subsystem_tb.sv ====
`timescale 1ns/100ps

module retry_subsystem_tb;

  import pcie_datalink_pkg::*;
  import retry_ctrl_pkg::*;

  localparam int TIMEOUT = 500;  // cycles per wait

  logic       clk_i;
  logic       rst_i;
  tlp_data_t  s_tdata;
  tlp_keep_t  s_tkeep;
  tlp_user_t  s_tuser;
  logic       s_tlast;
  logic       s_tvalid;
  logic       s_tready;
  tlp_data_t  m_tdata;
  tlp_keep_t  m_tkeep;
  tlp_user_t  m_tuser;
  logic       m_tlast;
  logic       m_tvalid;
  logic       m_tready;
  slot_mask_t retry_valid;
  slot_mask_t purge;
  slot_mask_t retry_ack;
  slot_mask_t retry_complete;
  slot_mask_t occupied;
  logic       stall_en;

  retry_subsystem i_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .s_axis_tdata_i   (s_tdata),
    .s_axis_tkeep_i   (s_tkeep),
    .s_axis_tuser_i   (s_tuser),
    .s_axis_tlast_i   (s_tlast),
    .s_axis_tvalid_i  (s_tvalid),
    .s_axis_tready_o  (s_tready),
    .m_axis_tdata_o   (m_tdata),
    .m_axis_tkeep_o   (m_tkeep),
    .m_axis_tuser_o   (m_tuser),
    .m_axis_tlast_o   (m_tlast),
    .m_axis_tvalid_o  (m_tvalid),
    .m_axis_tready_i  (m_tready),
    .retry_valid_i    (retry_valid),
    .purge_i          (purge),
    .retry_ack_o      (retry_ack),
    .retry_complete_o (retry_complete),
    .occupied_o       (occupied)
  );

  retry_checker i_chk (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .m_tdata_i  (m_tdata),
    .m_tkeep_i  (m_tkeep),
    .m_tuser_i  (m_tuser),
    .m_tlast_i  (m_tlast),
    .m_tvalid_i (m_tvalid),
    .m_tready_i (m_tready),
    .ack_i      (retry_ack),
    .complete_i (retry_complete)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // output back-pressure
  initial begin
    void'($urandom(32'h79f1_c945));
    forever begin
      @(posedge clk_i);
      if (stall_en) begin
        m_tready <= ($urandom % 4) != 0;  // about one stall in four
      end else begin
        m_tready <= 1'b1;
      end
    end
  end

  task automatic send_tlp(input int fd, input string name, input int n);
    tlp_data_t w;
    int        cnt;
    bit        done;
    for (int i = 0; i < n; i++) begin
      void'($fscanf(fd, "%h", w));
      s_tdata  <= w;
      s_tuser  <= tlp_user_t'(i % 2);  // user bit alternates per beat
      s_tlast  <= (i == n - 1);
      s_tvalid <= 1'b1;
      cnt  = 0;
      done = 0;
      while (!done) begin
        @(posedge clk_i);
        cnt++;
        if (s_tready) begin
          done = 1;
        end else if (cnt > TIMEOUT) begin
          i_chk.report_failure(name, "input beat was not accepted before the timeout");
          done = 1;
        end
      end
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
  endtask

  task automatic run_retry(input slot_mask_t mask);
    slot_mask_t pend;
    int         cnt;
    pend        = mask;
    retry_valid <= pend;
    cnt         = 0;
    while (pend != '0 && cnt <= TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
      if (retry_complete != '0) begin
        pend        = pend & ~retry_complete;  // drop the finished request
        retry_valid <= pend;
        cnt         = 0;
      end
    end
    if (pend != '0) begin
      i_chk.report_failure("retry", "replay did not complete before the timeout");
      retry_valid <= '0;
    end
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
    end while ((retry_ack != '0 || m_tvalid) && cnt <= TIMEOUT);
    if (cnt > TIMEOUT) i_chk.report_failure("wait_idle", "replay engine did not go idle");
  endtask

  // a free slot is already visible, so ready must be high at the first edge
  task automatic wait_ready(input string name);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
    end while (!s_tready && cnt < TIMEOUT);
    if (!s_tready) begin
      i_chk.report_failure(name, "s_axis_tready_o did not rise before the timeout");
    end else begin
      i_chk.check_latency(name, 1, cnt);
    end
  endtask

  task automatic check_full(input string name, input int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(posedge clk_i);
      seen = seen | s_tready;
    end
    i_chk.check_mask(name, '0, {3'b000, seen});
  endtask

  initial begin
    int         fd;
    int         n;
    int         slot;
    string      cmd;
    string      name;
    string      line;
    tlp_data_t  w;
    slot_mask_t mask;
    rst_i       = 1'b1;
    s_tdata     = '0;
    s_tkeep     = '1;
    s_tuser     = '0;
    s_tlast     = 1'b0;
    s_tvalid    = 1'b0;
    m_tready    = 1'b0;
    retry_valid = '0;
    purge       = '0;
    stall_en    = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    fd = $fopen("dv/retry_trace.txt", "r");
    if (fd == 0) begin
      i_chk.report_failure("trace", "could not open dv/retry_trace.txt");
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd.substr(0, 0) == "#") begin
          void'($fgets(line, fd));
        end else if (cmd == "tlp") begin
          void'($fscanf(fd, "%s %d", name, n));
          send_tlp(fd, name, n);
        end else if (cmd == "expect") begin
          void'($fscanf(fd, "%s %d %d", name, slot, n));
          i_chk.add_test(name, slot, n);
          repeat (n) begin
            void'($fscanf(fd, "%h", w));
            i_chk.add_word(w);
          end
        end else if (cmd == "retry") begin
          void'($fscanf(fd, "%h", mask));
          run_retry(mask);
        end else if (cmd == "purge") begin
          void'($fscanf(fd, "%h", mask));
          purge <= mask;
          @(posedge clk_i);
          purge <= '0;
        end else if (cmd == "stall") begin
          void'($fscanf(fd, "%d", n));
          stall_en <= (n != 0);
        end else if (cmd == "occ") begin
          void'($fscanf(fd, "%s %h", name, mask));
          @(posedge clk_i);
          i_chk.check_mask(name, mask, occupied);
        end else if (cmd == "full") begin
          void'($fscanf(fd, "%s %d", name, n));
          check_full(name, n);
        end else if (cmd == "wait_ready") begin
          void'($fscanf(fd, "%s", name));
          wait_ready(name);
        end else if (cmd == "wait_idle") begin
          wait_idle();
        end else begin
          i_chk.report_failure("trace", {"unknown command ", cmd});
        end
      end
      $fclose(fd);
    end
    repeat (4) @(posedge clk_i);
    if (i_chk.pending() != 0) begin
      i_chk.report_failure("trace", "expected replays never completed");
    end
    $display("tests passed: %0d, tests failed: %0d", i_chk.pass_cnt, i_chk.fail_cnt);
    if (i_chk.fail_cnt == 0 && i_chk.pass_cnt > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== dv/retry_trace.txt ====
# tlp <name> <beats> <hex words> | expect <test> <slot> <beats> <hex words>
# retry/purge <hex mask> | stall <0|1> | occ <test> <hex mask> | full <test> <cycles>
stall 0
tlp tlp_a 3 a0000001 a0000002 a0000003
occ occ_slot0 1
expect single_replay 0 3 a0000001 a0000002 a0000003
retry 1
wait_idle
tlp tlp_b 2 b0000001 b0000002
occ occ_slot1 3
tlp tlp_c 4 c0000001 c0000002 c0000003 c0000004
occ occ_slot2 7
tlp tlp_d 1 d0000001
occ occ_slot3 f
full full_blocks_input 8
# several requests at once, ascending grant order
expect multi_s0 0 3 a0000001 a0000002 a0000003
expect multi_s1 1 2 b0000001 b0000002
expect multi_s2 2 4 c0000001 c0000002 c0000003 c0000004
retry 7
wait_idle
expect repeat_first 3 1 d0000001
retry 8
wait_idle
expect repeat_second 3 1 d0000001
retry 8
wait_idle
stall 1
expect stalled_replay 2 4 c0000001 c0000002 c0000003 c0000004
retry 4
wait_idle
stall 0
purge 2
occ purge_slot1 d
wait_ready ready_after_purge
tlp tlp_e 3 e0000001 e0000002 e0000003
occ refill_slot1 f
expect refill_replay 1 3 e0000001 e0000002 e0000003
retry 2
wait_idle

// ==== retry_subsystem.f ====
+incdir+source
source/pcie_datalink_pkg.sv
source/retry_ctrl_pkg.sv
source/axis_retry_fifo.sv
source/retry_slot_alloc.sv
source/retry_transmit.sv
source/retry_subsystem.sv
dv/retry_subsystem_properties.sv
dv/retry_checker.sv
dv/retry_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: retry_subsystem

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/pcie_datalink_pkg.sv
      - source/retry_ctrl_pkg.sv
      - source/axis_retry_fifo.sv
      - source/retry_slot_alloc.sv
      - source/retry_transmit.sv
      - source/retry_subsystem.sv
  - target: test
    files:
      - dv/retry_subsystem_properties.sv
      - dv/retry_checker.sv
      - dv/retry_subsystem_tb.sv
